// ==== verilog/fpu_seq_pkg.sv ====
// ========================================
// FPU sequencer package
// Opcode tables, instruction views, loop config
// ========================================
package fpu_seq_pkg;

  localparam int unsigned RptBits     = 16;
  localparam int unsigned MaxInstBits = 11;
  localparam logic [6:0]  OpcodeFrep  = 7'b0001011;

  // Instructions that sync the int and float pipelines
  typedef struct packed {
    logic [31:0] match;
    logic [31:0] mask;
  } direct_op_t;

  localparam int unsigned NumDirect = 16;
  localparam direct_op_t DirectOps [NumDirect] = '{
    '{32'hE0000053, 32'hFFF0707F},  // fmv.x.w
    '{32'hF0000053, 32'hFFF0707F},  // fmv.w.x
    '{32'hA0002053, 32'hFE00707F},  // feq.s
    '{32'hA0001053, 32'hFE00707F},  // flt.s
    '{32'hA0000053, 32'hFE00707F},  // fle.s
    '{32'hE0001053, 32'hFFF0707F},  // fclass.s
    '{32'hC0000053, 32'hFFF0007F},  // fcvt.w.s
    '{32'hC0100053, 32'hFFF0007F},  // fcvt.wu.s
    '{32'hD0000053, 32'hFFF0007F},  // fcvt.s.w
    '{32'hD0100053, 32'hFFF0007F},  // fcvt.s.wu
    '{32'h00001073, 32'h0000707F},  // csrrw
    '{32'h00002073, 32'h0000707F},  // csrrs
    '{32'h00003073, 32'h0000707F},  // csrrc
    '{32'h00005073, 32'h0000707F},  // csrrwi
    '{32'h00006073, 32'h0000707F},  // csrrsi
    '{32'h00007073, 32'h0000707F}   // csrrci
  };

  typedef struct packed {
    logic [11:0] max_inst;
    logic [4:0]  rs1;
    logic [2:0]  stagger_max;
    logic [3:0]  stagger_mask;
    logic        is_outer;
    logic [6:0]  opcode;
  } seq_frep_t;

  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } seq_fp_t;

  // Same word read as FREP config or as FP register fields
  typedef union packed {
    seq_frep_t frep;
    seq_fp_t   fp;
  } seq_instr_u;

  typedef struct packed {
    logic                   is_outer;
    logic [MaxInstBits-1:0] max_inst;
    logic [RptBits-1:0]     max_rpt;
    logic [2:0]             stagger_max;
    logic [3:0]             stagger_mask;
    logic [MaxInstBits-1:0] base_pointer;
  } seq_cfg_t;

endpackage

// ==== verilog/seq_rb_if.sv ====
// ========================================
// Loop controller to ring buffer link
// ========================================
`timescale 1ns/1ps

interface seq_rb_if #(
  parameter int unsigned Depth     = 16,
  parameter int unsigned AddrWidth = 32
);
  localparam int unsigned PtrBits = $clog2(Depth) + 1;

  logic [31:0]          rd_op;
  logic [AddrWidth-1:0] rd_argc;
  logic                 empty;
  logic                 has_instrs;
  logic [PtrBits-1:0]   wr_pointer;
  logic [PtrBits-1:0]   base_pointer;
  logic [PtrBits-1:0]   rd_offset;
  logic                 retire;
  logic [PtrBits-1:0]   retire_len;

  modport ctrl (
    input  rd_op, rd_argc, empty, has_instrs, base_pointer,
    output rd_offset, retire, retire_len
  );

  modport rb (
    output rd_op, rd_argc, empty, has_instrs, wr_pointer, base_pointer,
    input  rd_offset, retire, retire_len
  );
endinterface

// ==== verilog/seq_cfg_fifo.sv ====
// ========================================
// Loop configuration FIFO
// Holds decoded FREP configs in order
// ========================================
`timescale 1ns/1ps

module seq_cfg_fifo #(
  parameter int unsigned CfgDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  push_i,
  input  fpu_seq_pkg::seq_cfg_t cfg_i,
  input  logic                  pop_i,
  output logic                  full_o,
  output logic                  empty_o,
  output fpu_seq_pkg::seq_cfg_t cfg_o
);
  import fpu_seq_pkg::*;

  localparam int unsigned IdxBits = $clog2(CfgDepth);

  seq_cfg_t mem [CfgDepth];
  // Extra MSB separates full from empty
  logic [IdxBits:0] wr_ptr_q;
  logic [IdxBits:0] rd_ptr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q[IdxBits-1:0]] <= cfg_i;
    end
  end

  assign cfg_o   = mem[rd_ptr_q[IdxBits-1:0]];
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = ((wr_ptr_q ^ rd_ptr_q) == {1'b1, {IdxBits{1'b0}}});

endmodule

// ==== verilog/seq_ring_buffer.sv ====
// ========================================
// Sequencer ring buffer
// Stores FP instructions for loop replay
// ========================================
`timescale 1ns/1ps

module seq_ring_buffer #(
  parameter int unsigned Depth     = 16,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 wr_en_i,
  input  logic [31:0]          wr_op_i,
  input  logic [AddrWidth-1:0] wr_argc_i,
  output logic                 full_o,
  seq_rb_if.rb                 rb_if
);
  localparam int unsigned IdxBits = $clog2(Depth);
  localparam int unsigned PtrBits = IdxBits + 1;

  logic [31:0]          op_mem   [Depth];
  logic [AddrWidth-1:0] argc_mem [Depth];

  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] base_ptr_q;
  logic [PtrBits-1:0] rd_ptr;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      base_ptr_q <= '0;
    end else begin
      if (wr_en_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // Whole loop body is released at once
      if (rb_if.retire) begin
        base_ptr_q <= base_ptr_q + rb_if.retire_len;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      op_mem[wr_ptr_q[IdxBits-1:0]]   <= wr_op_i;
      argc_mem[wr_ptr_q[IdxBits-1:0]] <= wr_argc_i;
    end
  end

  assign rd_ptr = base_ptr_q + rb_if.rd_offset;

  assign rb_if.rd_op        = op_mem[rd_ptr[IdxBits-1:0]];
  assign rb_if.rd_argc      = argc_mem[rd_ptr[IdxBits-1:0]];
  assign rb_if.empty        = (rd_ptr == wr_ptr_q);
  assign rb_if.has_instrs   = (base_ptr_q != wr_ptr_q);
  assign rb_if.wr_pointer   = wr_ptr_q;
  assign rb_if.base_pointer = base_ptr_q;

  // Occupancy counts from the loop base, not the read point
  assign full_o = ((base_ptr_q ^ wr_ptr_q) == {1'b1, {IdxBits{1'b0}}});

endmodule

// ==== verilog/seq_loop_ctrl.sv ====
// ========================================
// Loop controller
// Steps loop counters, staggers registers
// ========================================
`timescale 1ns/1ps

module seq_loop_ctrl #(
  parameter int unsigned Depth     = 16,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  fpu_seq_pkg::seq_cfg_t cfg_i,
  input  logic                  cfg_empty_i,
  input  logic                  ready_i,
  output logic                  cfg_pop_o,
  output logic                  valid_o,
  output logic [31:0]           op_o,
  output logic [AddrWidth-1:0]  argc_o,
  output logic                  repd_o,
  seq_rb_if.ctrl                rb_if
);
  import fpu_seq_pkg::*;

  localparam int unsigned PtrBits = $clog2(Depth) + 1;

  seq_cfg_t           curr_cfg;
  logic               cfg_match;
  logic [PtrBits-1:0] inst_cnt_q;
  logic [PtrBits-1:0] inst_cnt_d;
  logic [RptBits-1:0] rpt_cnt_q;
  logic [RptBits-1:0] rpt_cnt_d;
  logic [2:0]         stg_cnt_q;
  logic [2:0]         stg_cnt_d;
  logic               inst_last;
  logic               rpt_last;
  logic               stg_last;
  logic               issue;
  logic               loop_done;
  seq_instr_u         instr;

  // Config only applies once the buffer base reaches its first instruction
  always_comb begin
    curr_cfg  = cfg_i;
    cfg_match = !cfg_empty_i && (cfg_i.base_pointer == MaxInstBits'(rb_if.base_pointer));
    if (!cfg_match) begin
      curr_cfg.max_inst     = '0;
      curr_cfg.max_rpt      = '0;
      curr_cfg.stagger_mask = '0;
    end
  end

  assign inst_last = (MaxInstBits'(inst_cnt_q) == curr_cfg.max_inst);
  assign rpt_last  = (rpt_cnt_q == curr_cfg.max_rpt);
  assign stg_last  = (stg_cnt_q == curr_cfg.stagger_max);
  assign issue     = valid_o & ready_i;
  assign loop_done = issue & inst_last & rpt_last;

  always_comb begin
    inst_cnt_d = inst_cnt_q;
    rpt_cnt_d  = rpt_cnt_q;
    stg_cnt_d  = stg_cnt_q;
    if (loop_done) begin
      inst_cnt_d = '0;
      rpt_cnt_d  = '0;
      stg_cnt_d  = '0;
    end else if (issue) begin
      if (curr_cfg.is_outer) begin
        // Body runs through, then the repeat count steps
        if (inst_last) begin
          inst_cnt_d = '0;
          rpt_cnt_d  = rpt_cnt_q + 1'b1;
          stg_cnt_d  = stg_last ? '0 : stg_cnt_q + 1'b1;
        end else begin
          inst_cnt_d = inst_cnt_q + 1'b1;
        end
      end else begin
        stg_cnt_d = stg_last ? '0 : stg_cnt_q + 1'b1;
        if (rpt_last) begin
          rpt_cnt_d  = '0;
          inst_cnt_d = inst_cnt_q + 1'b1;
        end else begin
          rpt_cnt_d = rpt_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inst_cnt_q <= '0;
      rpt_cnt_q  <= '0;
      stg_cnt_q  <= '0;
    end else begin
      inst_cnt_q <= inst_cnt_d;
      rpt_cnt_q  <= rpt_cnt_d;
      stg_cnt_q  <= stg_cnt_d;
    end
  end

  // Register staggering wraps modulo 32
  always_comb begin
    instr = rb_if.rd_op;
    if (curr_cfg.stagger_mask[0]) begin
      instr.fp.rd = instr.fp.rd + 5'(stg_cnt_q);
    end
    if (curr_cfg.stagger_mask[1]) begin
      instr.fp.rs1 = instr.fp.rs1 + 5'(stg_cnt_q);
    end
    if (curr_cfg.stagger_mask[2]) begin
      instr.fp.rs2 = instr.fp.rs2 + 5'(stg_cnt_q);
    end
    if (curr_cfg.stagger_mask[3]) begin
      instr.fp.rs3 = instr.fp.rs3 + 5'(stg_cnt_q);
    end
  end

  assign valid_o   = ~rb_if.empty;
  assign op_o      = instr;
  assign argc_o    = rb_if.rd_argc;
  assign repd_o    = (rpt_cnt_q != '0);
  assign cfg_pop_o = loop_done & cfg_match;

  assign rb_if.rd_offset  = inst_cnt_q;
  assign rb_if.retire     = loop_done;
  assign rb_if.retire_len = PtrBits'(curr_cfg.max_inst) + 1'b1;

endmodule

// ==== verilog/seq_issue_router.sv ====
// ========================================
// Issue router
// Classifies requests, muxes the output
// ========================================
`timescale 1ns/1ps

module seq_issue_router #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned AddrWidth = 32
) (
  input  logic [31:0]          inp_qdata_op_i,
  input  logic [DataWidth-1:0] inp_qdata_arga_i,
  input  logic [DataWidth-1:0] inp_qdata_argb_i,
  input  logic [AddrWidth-1:0] inp_qdata_argc_i,
  input  logic                 inp_qvalid_i,
  output logic                 inp_qready_o,
  input  logic                 rb_ready_i,
  input  logic                 cfg_ready_i,
  input  logic                 has_instrs_i,
  input  logic                 seq_valid_i,
  input  logic [31:0]          seq_op_i,
  input  logic [AddrWidth-1:0] seq_argc_i,
  input  logic                 seq_repd_i,
  output logic                 rb_push_o,
  output logic                 cfg_push_o,
  output logic                 seq_ready_o,
  output logic [31:0]          oup_qdata_op_o,
  output logic [DataWidth-1:0] oup_qdata_arga_o,
  output logic [DataWidth-1:0] oup_qdata_argb_o,
  output logic [AddrWidth-1:0] oup_qdata_argc_o,
  output logic                 oup_qdata_repd_o,
  output logic                 oup_qvalid_o,
  input  logic                 oup_qready_i
);
  import fpu_seq_pkg::*;

  seq_instr_u inp_instr;
  logic       is_frep;
  logic       is_direct;
  logic       direct_ready;

  assign inp_instr = inp_qdata_op_i;

  always_comb begin
    is_frep   = (inp_instr.frep.opcode == OpcodeFrep);
    is_direct = 1'b0;
    for (int i = 0; i < NumDirect; i++) begin
      if ((inp_qdata_op_i & DirectOps[i].mask) == DirectOps[i].match) begin
        is_direct = 1'b1;
      end
    end
  end

  // Direct ops must wait until buffered work has drained
  assign direct_ready = oup_qready_i & ~has_instrs_i;

  assign inp_qready_o = is_frep   ? cfg_ready_i :
                        is_direct ? direct_ready : rb_ready_i;
  assign cfg_push_o   = inp_qvalid_i & is_frep & cfg_ready_i;
  assign rb_push_o    = inp_qvalid_i & ~is_frep & ~is_direct & rb_ready_i;
  assign seq_ready_o  = has_instrs_i & oup_qready_i;

  always_comb begin
    if (has_instrs_i) begin
      oup_qvalid_o     = seq_valid_i;
      oup_qdata_op_o   = seq_op_i;
      oup_qdata_arga_o = '0;
      oup_qdata_argb_o = '0;
      oup_qdata_argc_o = seq_argc_i;
      oup_qdata_repd_o = seq_repd_i;
    end else begin
      oup_qvalid_o     = inp_qvalid_i & is_direct;
      oup_qdata_op_o   = inp_qdata_op_i;
      oup_qdata_arga_o = inp_qdata_arga_i;
      oup_qdata_argb_o = inp_qdata_argb_i;
      oup_qdata_argc_o = inp_qdata_argc_i;
      oup_qdata_repd_o = 1'b0;
    end
  end

endmodule

// ==== verilog/fpu_sequencer.sv ====
// ========================================
// FPU instruction sequencer
// Replays FP loops, forwards sync ops
// ========================================
`timescale 1ns/1ps

module fpu_sequencer #(
  parameter int unsigned Depth     = 16,
  parameter int unsigned CfgDepth  = 4,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [31:0]          inp_qdata_op_i,
  input  logic [DataWidth-1:0] inp_qdata_arga_i,
  input  logic [DataWidth-1:0] inp_qdata_argb_i,
  input  logic [AddrWidth-1:0] inp_qdata_argc_i,
  input  logic                 inp_qvalid_i,
  output logic                 inp_qready_o,
  output logic [31:0]          oup_qdata_op_o,
  output logic [DataWidth-1:0] oup_qdata_arga_o,
  output logic [DataWidth-1:0] oup_qdata_argb_o,
  output logic [AddrWidth-1:0] oup_qdata_argc_o,
  output logic                 oup_qdata_repd_o,
  output logic                 oup_qvalid_o,
  input  logic                 oup_qready_i
);
  import fpu_seq_pkg::*;

  seq_instr_u           inp_instr;
  seq_cfg_t             cfg_in;
  seq_cfg_t             cfg_out;
  logic                 cfg_full;
  logic                 cfg_empty;
  logic                 cfg_push;
  logic                 cfg_pop;
  logic                 rb_full;
  logic                 rb_push;
  logic                 seq_valid;
  logic                 seq_ready;
  logic                 seq_repd;
  logic [31:0]          seq_op;
  logic [AddrWidth-1:0] seq_argc;

  seq_rb_if #(
    .Depth     (Depth),
    .AddrWidth (AddrWidth)
  ) rb_if ();

  assign inp_instr = inp_qdata_op_i;

  // FREP fields plus repeat count from arga, anchored at the next write slot
  always_comb begin
    cfg_in.is_outer     = inp_instr.frep.is_outer;
    cfg_in.max_inst     = inp_instr.frep.max_inst[MaxInstBits-1:0];
    cfg_in.max_rpt      = inp_qdata_arga_i[RptBits-1:0];
    cfg_in.stagger_max  = inp_instr.frep.stagger_max;
    cfg_in.stagger_mask = inp_instr.frep.stagger_mask;
    cfg_in.base_pointer = MaxInstBits'(rb_if.wr_pointer);
  end

  seq_issue_router #(
    .DataWidth (DataWidth),
    .AddrWidth (AddrWidth)
  ) u_router (
    .inp_qdata_op_i   (inp_qdata_op_i),
    .inp_qdata_arga_i (inp_qdata_arga_i),
    .inp_qdata_argb_i (inp_qdata_argb_i),
    .inp_qdata_argc_i (inp_qdata_argc_i),
    .inp_qvalid_i     (inp_qvalid_i),
    .inp_qready_o     (inp_qready_o),
    .rb_ready_i       (~rb_full),
    .cfg_ready_i      (~cfg_full),
    .has_instrs_i     (rb_if.has_instrs),
    .seq_valid_i      (seq_valid),
    .seq_op_i         (seq_op),
    .seq_argc_i       (seq_argc),
    .seq_repd_i       (seq_repd),
    .rb_push_o        (rb_push),
    .cfg_push_o       (cfg_push),
    .seq_ready_o      (seq_ready),
    .oup_qdata_op_o   (oup_qdata_op_o),
    .oup_qdata_arga_o (oup_qdata_arga_o),
    .oup_qdata_argb_o (oup_qdata_argb_o),
    .oup_qdata_argc_o (oup_qdata_argc_o),
    .oup_qdata_repd_o (oup_qdata_repd_o),
    .oup_qvalid_o     (oup_qvalid_o),
    .oup_qready_i     (oup_qready_i)
  );

  seq_cfg_fifo #(
    .CfgDepth (CfgDepth)
  ) u_cfg_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (cfg_push),
    .cfg_i   (cfg_in),
    .pop_i   (cfg_pop),
    .full_o  (cfg_full),
    .empty_o (cfg_empty),
    .cfg_o   (cfg_out)
  );

  seq_ring_buffer #(
    .Depth     (Depth),
    .AddrWidth (AddrWidth)
  ) u_ring_buffer (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_en_i   (rb_push),
    .wr_op_i   (inp_qdata_op_i),
    .wr_argc_i (inp_qdata_argc_i),
    .full_o    (rb_full),
    .rb_if     (rb_if.rb)
  );

  seq_loop_ctrl #(
    .Depth     (Depth),
    .AddrWidth (AddrWidth)
  ) u_loop_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg_out),
    .cfg_empty_i (cfg_empty),
    .ready_i     (seq_ready),
    .cfg_pop_o   (cfg_pop),
    .valid_o     (seq_valid),
    .op_o        (seq_op),
    .argc_o      (seq_argc),
    .repd_o      (seq_repd),
    .rb_if       (rb_if.ctrl)
  );

endmodule

// ==== verification/seq_clk_gen.sv ====
// ========================================
// Testbench clock and reset generator
// ========================================
`timescale 1ns/1ps

module seq_clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset drops away on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== verification/fpu_sequencer_tb.sv ====
// ========================================
// FPU sequencer testbench
// Loop expansion model checked against issues
// ========================================
`timescale 1ns/1ps

module fpu_sequencer_tb;

  localparam int ClkPeriod      = 40;
  localparam int ResetCycles    = 10;
  // Worst case issue count over all six tests
  localparam int TotalIssues    = 2 + 8 + 12 + 9 + 16 + 102;
  localparam int WatchdogCycles = TotalIssues * 4 + 200 + ResetCycles;

  typedef struct packed {
    logic [31:0] op;
    logic [31:0] arga;
    logic [31:0] argb;
    logic [31:0] argc;
    logic        repd;
    logic        direct;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] inp_qdata_op_i;
  logic [31:0] inp_qdata_arga_i;
  logic [31:0] inp_qdata_argb_i;
  logic [31:0] inp_qdata_argc_i;
  logic        inp_qvalid_i;
  logic        inp_qready_o;
  logic [31:0] oup_qdata_op_o;
  logic [31:0] oup_qdata_arga_o;
  logic [31:0] oup_qdata_argb_o;
  logic [31:0] oup_qdata_argc_o;
  logic        oup_qdata_repd_o;
  logic        oup_qvalid_o;
  logic        oup_qready_i;

  exp_t        exp_q[$];
  exp_t        head_exp;
  logic [31:0] body_op   [8];
  logic [31:0] body_argc [8];
  logic        random_mode;
  logic        cur_direct;
  int          err_cnt;
  int          check_cnt;
  int          tests_passed;
  int          blocked_cycles;

  seq_clk_gen #(
    .PeriodNs    (ClkPeriod),
    .ResetCycles (ResetCycles)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fpu_sequencer #(
    .Depth     (16),
    .CfgDepth  (4),
    .DataWidth (32),
    .AddrWidth (32)
  ) UUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .inp_qdata_op_i   (inp_qdata_op_i),
    .inp_qdata_arga_i (inp_qdata_arga_i),
    .inp_qdata_argb_i (inp_qdata_argb_i),
    .inp_qdata_argc_i (inp_qdata_argc_i),
    .inp_qvalid_i     (inp_qvalid_i),
    .inp_qready_o     (inp_qready_o),
    .oup_qdata_op_o   (oup_qdata_op_o),
    .oup_qdata_arga_o (oup_qdata_arga_o),
    .oup_qdata_argb_o (oup_qdata_argb_o),
    .oup_qdata_argc_o (oup_qdata_argc_o),
    .oup_qdata_repd_o (oup_qdata_repd_o),
    .oup_qvalid_o     (oup_qvalid_o),
    .oup_qready_i     (oup_qready_i)
  );

  // R4-type layout with rm and fmt left at zero
  function automatic logic [31:0] fp_op(input logic [6:0] opc, input logic [4:0] rs3,
                                        input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [4:0] rd);
    return {rs3, 2'b00, rs2, rs1, 3'b000, rd, opc};
  endfunction

  function automatic logic [31:0] frep_op(input int mi, input int smax,
                                          input logic [3:0] smask, input logic outer);
    return {1'b0, 11'(mi), 5'd0, 3'(smax), smask, outer, 7'b0001011};
  endfunction

  // Register fields advance by the stagger count and wrap at 32
  function automatic logic [31:0] stagger(input logic [31:0] op, input logic [3:0] mask,
                                          input int cnt);
    logic [31:0] r;
    logic [4:0]  c;
    r = op;
    c = 5'(cnt);
    if (mask[0]) r[11:7]  = op[11:7] + c;
    if (mask[1]) r[19:15] = op[19:15] + c;
    if (mask[2]) r[24:20] = op[24:20] + c;
    if (mask[3]) r[31:27] = op[31:27] + c;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic push_exp(input logic [31:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c, input logic repd, input logic dir);
    exp_t e;
    e.op     = op;
    e.arga   = a;
    e.argb   = b;
    e.argc   = c;
    e.repd   = repd;
    e.direct = dir;
    exp_q.push_back(e);
  endtask

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_req(input logic [31:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c, input logic dir);
    inp_qdata_op_i   = op;
    inp_qdata_arga_i = a;
    inp_qdata_argb_i = b;
    inp_qdata_argc_i = c;
    cur_direct       = dir;
    inp_qvalid_i     = 1'b1;
    @(posedge clk);
    while (!inp_qready_o) @(posedge clk);
    @(negedge clk);
    inp_qvalid_i = 1'b0;
    cur_direct   = 1'b0;
  endtask

  task automatic send_buffered(input logic [31:0] op, input logic [31:0] c);
    push_exp(op, 32'd0, 32'd0, c, 1'b0, 1'b0);
    send_req(op, $urandom, $urandom, c, 1'b0);
  endtask

  task automatic send_direct(input logic [31:0] op, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] c);
    push_exp(op, a, b, c, 1'b0, 1'b1);
    send_req(op, a, b, c, 1'b1);
  endtask

  // Expands the loop held in body_op into its issue order and then sends it
  task automatic run_loop(input logic outer, input int mi, input int mr, input int smax,
                          input logic [3:0] smask);
    int k;
    k = 0;
    if (outer) begin
      for (int r = 0; r <= mr; r++) begin
        for (int j = 0; j <= mi; j++) begin
          push_exp(stagger(body_op[j], smask, r % (smax + 1)), 32'd0, 32'd0, body_argc[j],
                   r != 0, 1'b0);
        end
      end
    end else begin
      for (int j = 0; j <= mi; j++) begin
        for (int r = 0; r <= mr; r++) begin
          push_exp(stagger(body_op[j], smask, k % (smax + 1)), 32'd0, 32'd0, body_argc[j],
                   r != 0, 1'b0);
          k++;
        end
      end
    end
    send_req(frep_op(mi, smax, smask, outer), 32'(mr), 32'd0, 32'd0, 1'b0);
    for (int j = 0; j <= mi; j++) begin
      send_req(body_op[j], $urandom, $urandom, body_argc[j], 1'b0);
    end
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    assert (!oup_qvalid_o) else begin
      err_cnt++;
      $display("Output still valid after all expected issues in test %0d", num);
    end
    if (err_cnt == errs_before) tests_passed++;
    $display("Test %0d %s: %s", num, name, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  // Output monitor sampling on the rising edge before any register update
  always @(posedge clk) begin
    if (rst_n) begin
      if (cur_direct && inp_qvalid_i && exp_q.size() > 0 && !exp_q[0].direct) begin
        blocked_cycles++;
        assert (!inp_qready_o) else begin
          err_cnt++;
          $display("Direct op accepted at %0t ns while buffered issues were pending", $time);
        end
      end
      if (oup_qvalid_o && oup_qready_i) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Unexpected issue of %h at %0t ns", oup_qdata_op_o, $time);
        end else begin
          head_exp = exp_q.pop_front();
          check_value("oup_qdata_op_o", oup_qdata_op_o, head_exp.op);
          check_value("oup_qdata_arga_o", oup_qdata_arga_o, head_exp.arga);
          check_value("oup_qdata_argb_o", oup_qdata_argb_o, head_exp.argb);
          check_value("oup_qdata_argc_o", oup_qdata_argc_o, head_exp.argc);
          check_value("oup_qdata_repd_o", 32'(oup_qdata_repd_o), 32'(head_exp.repd));
        end
      end
    end
  end

  // A stalled issue keeps its valid, its instruction word and its side data
  assert property (@(posedge clk) disable iff (!rst_n)
    (oup_qvalid_o && !oup_qready_i) |=> (oup_qvalid_o && $stable(oup_qdata_op_o) &&
                                         $stable(oup_qdata_argc_o) &&
                                         $stable(oup_qdata_repd_o)))
    else begin
      err_cnt++;
      $display("Stalled issue changed or dropped at %0t ns", $time);
    end

  initial begin
    oup_qready_i = 1'b1;
    forever begin
      @(negedge clk);
      oup_qready_i = random_mode ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: expected issues did not complete in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int errs;
    int mi;
    int mr;
    int smax;
    void'($urandom(94));
    inp_qdata_op_i   = '0;
    inp_qdata_arga_i = '0;
    inp_qdata_argb_i = '0;
    inp_qdata_argc_i = '0;
    inp_qvalid_i     = 1'b0;
    random_mode      = 1'b0;
    cur_direct       = 1'b0;
    err_cnt          = 0;
    check_cnt        = 0;
    tests_passed     = 0;
    blocked_cycles   = 0;
    wait (rst_n);
    @(negedge clk);

    errs = err_cnt;
    check_value("oup_qvalid_o", 32'(oup_qvalid_o), 32'd0);
    send_buffered(fp_op(7'h53, 5'd0, 5'd2, 5'd1, 5'd3), 32'h0000_1234);
    send_buffered(fp_op(7'h43, 5'd9, 5'd8, 5'd7, 5'd6), 32'h0000_5678);
    end_test(1, "single FP ops", errs);

    errs = err_cnt;
    send_direct({12'hE00, 5'd7, 3'b000, 5'd5, 7'h53}, 32'hA5A5_0001, 32'h5A5A_0002, 32'h0000_0C03);
    body_op[0]   = fp_op(7'h53, 5'd2, 5'd4, 5'd3, 5'd2);
    body_argc[0] = 32'h0000_0100;
    run_loop(1'b0, 0, 5, 0, 4'b0000);
    send_direct({7'b1010000, 5'd2, 5'd1, 3'b010, 5'd10, 7'h53}, 32'h1111_2222, 32'h3333_4444,
                32'h0000_0055);
    assert (blocked_cycles > 0) else begin
      err_cnt++;
      $display("Direct op was never held back while the loop ran");
    end
    end_test(2, "direct ops", errs);

    errs = err_cnt;
    for (int j = 0; j < 3; j++) begin
      body_op[j]   = fp_op(7'h53, 5'd0, 5'(j + 1), 5'(j + 8), 5'(j + 16));
      body_argc[j] = 32'h0000_0200 + 32'(j);
    end
    run_loop(1'b0, 2, 3, 0, 4'b0000);
    end_test(3, "inner FREP", errs);

    errs = err_cnt;
    run_loop(1'b1, 2, 2, 0, 4'b0000);
    end_test(4, "outer FREP", errs);

    errs = err_cnt;
    body_op[0] = fp_op(7'h53, 5'd0, 5'd4, 5'd31, 5'd30);
    body_op[1] = fp_op(7'h53, 5'd0, 5'd5, 5'd29, 5'd28);
    run_loop(1'b0, 1, 3, 2, 4'b0011);
    body_op[0] = fp_op(7'h43, 5'd31, 5'd30, 5'd1, 5'd2);
    body_op[1] = fp_op(7'h43, 5'd20, 5'd31, 5'd3, 5'd4);
    run_loop(1'b1, 1, 3, 1, 4'b1100);
    end_test(5, "register stagger", errs);

    errs = err_cnt;
    @(posedge clk);
    random_mode = 1'b1;
    @(negedge clk);
    for (int n = 0; n < 6; n++) begin
      mi   = $urandom_range(3);
      mr   = $urandom_range(3);
      smax = $urandom_range(3);
      // Fused multiply-add opcodes only, so no body op decodes as a direct op
      for (int j = 0; j <= mi; j++) begin
        body_op[j]   = fp_op({3'b100, 2'($urandom_range(3)), 2'b11}, 5'($urandom),
                             5'($urandom), 5'($urandom), 5'($urandom));
        body_argc[j] = $urandom;
      end
      run_loop($urandom_range(1) == 1, mi, mr, smax, 4'($urandom));
      if (n % 2 == 1) begin
        send_buffered(fp_op(7'h53, 5'd1, 5'($urandom), 5'($urandom), 5'($urandom)), $urandom);
        send_direct({7'b1110000, 5'd0, 5'($urandom), 3'b001, 5'($urandom), 7'h53}, $urandom,
                    $urandom, $urandom);
      end
    end
    end_test(6, "random back-pressure", errs);
    @(posedge clk);
    random_mode = 1'b0;
    @(negedge clk);

    $display("Summary: %0d of 6 tests passed, %0d checks, %0d errors", tests_passed, check_cnt,
             err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== fpu_sequencer.f ====
verilog/fpu_seq_pkg.sv
verilog/seq_rb_if.sv
verilog/seq_cfg_fifo.sv
verilog/seq_ring_buffer.sv
verilog/seq_loop_ctrl.sv
verilog/seq_issue_router.sv
verilog/fpu_sequencer.sv
verification/seq_clk_gen.sv
verification/fpu_sequencer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the FPU sequencer testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=fpu_sequencer_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module fpu_sequencer_tb \
  --Mdir obj_dir -o "$BIN" \
  -f fpu_sequencer.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
